// ==== files.f ====
load_pkg.sv
tag_stream_if.sv
load_pe.sv
load_mem.sv
load_top.sv
tb_clock_gen.sv
tb_load_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the load path testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_load_top_sim

rm -f "$LOG"

verilator --binary --timing -f files.f --top-module tb_load_top -o "$BIN" \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/"$BIN" > "$LOG" 2>&1 \
    ; cat "$LOG"

grep -q "Simulation FAILED" "$LOG" && { echo "Result: test failed"; exit 1; }
grep -q "Simulation PASSED" "$LOG" || { echo "Result: no pass line in $LOG"; exit 1; }

echo "Result: test passed"
exit 0

// ==== tb_load_top.sv ====
`timescale 1ns/1ps

module tb_load_top;
    import load_pkg::*;

    localparam int RESET_CYCLES    = 8;
    localparam int MEM_WORDS       = 2 ** ADDR_WIDTH;
    localparam int NUM_TAGS        = 2 ** TAG_WIDTH;
    localparam int RAND_GROUPS     = 6;
    localparam int GROUP_SIZE      = 8;
    localparam int NUM_FIXED       = 16;
    localparam int NUM_ROWS        = NUM_FIXED + RAND_GROUPS * GROUP_SIZE;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + MEM_WORDS + 40 * NUM_ROWS + 20;

    // One load operation; a row with last set closes a group that drains before the next
    typedef struct {
        bit         has_addr;
        addr_t      addr;
        tag_t       atag;
        int         addr_gap;
        bit         has_ctrl;
        tag_t       ctag;
        int         ctrl_gap;
        bit         do_write;
        logic [7:0] rdy_pat;
        bit         want_stall;
        bit         last;
    } load_row_t;

    logic  clk;
    logic  rst_n;
    logic  in_addr_valid;
    logic  in_addr_ready;
    tag_t  in_addr_tag;
    addr_t in_addr;
    logic  in_ctrl_valid;
    logic  in_ctrl_ready;
    tag_t  in_ctrl_tag;
    logic  out_valid;
    logic  out_ready;
    tag_t  out_tag;
    elem_t out_data;
    logic  wr_en;
    addr_t wr_addr;
    elem_t wr_data;

    load_row_t  rows [NUM_ROWS];
    int         n_rows = 0;
    elem_t      ref_mem [MEM_WORDS];
    int         seed;
    int         errors = 0;
    int         rsp_count = 0;
    int         exp_total = 0;
    logic [7:0] ready_pat = 8'hFF;
    int         ready_phase = 0;

    // Scoreboard indexed by tag
    bit    sb_addr_seen [NUM_TAGS];
    bit    sb_ctrl_seen [NUM_TAGS];
    int    sb_addr_edge [NUM_TAGS];
    int    sb_ctrl_edge [NUM_TAGS];
    elem_t sb_data      [NUM_TAGS];

    int    edge_idx = 0;
    int    grp_addr_cnt = 0;
    int    grp_ctrl_cnt = 0;
    bit    stall_seen = 1'b0;
    bit    exact_timing = 1'b0;
    logic  prev_stall = 1'b0;
    tag_t  prev_tag;
    elem_t prev_data;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    load_top #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .ELEM_WIDTH  (ELEM_WIDTH),
        .TAG_WIDTH   (TAG_WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_addr_valid (in_addr_valid),
        .in_addr_ready (in_addr_ready),
        .in_addr_tag   (in_addr_tag),
        .in_addr       (in_addr),
        .in_ctrl_valid (in_ctrl_valid),
        .in_ctrl_ready (in_ctrl_ready),
        .in_ctrl_tag   (in_ctrl_tag),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_tag       (out_tag),
        .out_data      (out_data),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %0b, actual %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_elem(input string name, input elem_t exp, input elem_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    // ----------------------------------------------------------------------
    // Stimulus tasks that are entered and left 1 ns after a rising edge
    // ----------------------------------------------------------------------

    task automatic add_row(input bit ha, input addr_t a, input tag_t at, input int ag,
                           input bit hc, input tag_t ct, input int cg, input bit wr,
                           input logic [7:0] pat, input bit ws, input bit last);
        rows[n_rows] = '{ha, a, at, ag, hc, ct, cg, wr, pat, ws, last};
        n_rows++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_word(input addr_t a, input elem_t d);
        wr_en   = 1'b1;
        wr_addr = a;
        wr_data = d;
        ref_mem[a] = d;
        idle_cycles(1);
        wr_en = 1'b0;
    endtask

    task automatic send_addr(input addr_t a, input tag_t t);
        in_addr_valid = 1'b1;
        in_addr       = a;
        in_addr_tag   = t;
        @(negedge clk);
        while (!in_addr_ready) @(negedge clk);
        idle_cycles(1);
        in_addr_valid = 1'b0;
    endtask

    task automatic send_ctrl(input tag_t t);
        in_ctrl_valid = 1'b1;
        in_ctrl_tag   = t;
        @(negedge clk);
        while (!in_ctrl_ready) @(negedge clk);
        idle_cycles(1);
        in_ctrl_valid = 1'b0;
    endtask

    task automatic drive_addr_stream(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (rows[i].has_addr) begin
                idle_cycles(rows[i].addr_gap);
                send_addr(rows[i].addr, rows[i].atag);
            end
        end
    endtask

    task automatic drive_ctrl_stream(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            if (rows[i].has_ctrl) begin
                idle_cycles(rows[i].ctrl_gap);
                send_ctrl(rows[i].ctag);
            end
        end
    endtask

    task automatic run_group(input int first, input int last);
        bit want_stall;
        want_stall = 1'b0;
        for (int i = first; i <= last; i++) begin
            if (rows[i].do_write) begin
                write_word(rows[i].addr, elem_t'($random(seed)));
            end
            if (rows[i].want_stall) begin
                want_stall = 1'b1;
            end
            if (rows[i].has_addr) begin
                exp_total++;
            end
        end
        grp_addr_cnt = 0;
        grp_ctrl_cnt = 0;
        stall_seen   = 1'b0;
        ready_pat    = rows[first].rdy_pat;
        // Fixed rows run without stalls or contention and have an exact latency
        exact_timing = (last < NUM_FIXED);
        fork
            drive_addr_stream(first, last);
            drive_ctrl_stream(first, last);
        join
        while (rsp_count < exp_total) @(posedge clk);
        #1;
        ready_pat = 8'hFF;
        idle_cycles(2);
        check_bit("out_valid", 1'b0, out_valid);
        if (want_stall && !stall_seen) begin
            note_failure("address input never stalled although the queue was full");
        end
    endtask

    task automatic build_random_rows();
        addr_t      a;
        tag_t       t;
        int         ag;
        int         cg;
        bit         wr;
        logic [7:0] pat;
        for (int g = 0; g < RAND_GROUPS; g++) begin
            for (int i = 0; i < GROUP_SIZE; i++) begin
                // Alternate tag halves so consecutive groups never share a tag
                t   = tag_t'((g % 2) * GROUP_SIZE + i);
                a   = addr_t'($random(seed));
                ag  = $random(seed) & 3;
                cg  = $random(seed) & 3;
                wr  = (($random(seed) & 7) == 0);
                pat = 8'($random(seed)) | 8'h01;
                add_row(1'b1, a, t, ag, 1'b1, t, cg, wr, pat, 1'b0, i == GROUP_SIZE - 1);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Response ready pattern
    // ----------------------------------------------------------------------

    initial begin
        logic next_ready;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            next_ready  = ready_pat[ready_phase];
            ready_phase = (ready_phase + 1) % 8;
            #1;
            out_ready = next_ready;
        end
    end

    // ----------------------------------------------------------------------
    // Monitor and scoreboard sampled on the falling edge
    // ----------------------------------------------------------------------

    always @(negedge clk) begin
        int later;
        if (rst_n) begin
            edge_idx = edge_idx + 1;
            if (in_addr_valid && !in_addr_ready) begin
                stall_seen = 1'b1;
                if (grp_ctrl_cnt == 0 && grp_addr_cnt != QUEUE_DEPTH) begin
                    note_failure($sformatf("address input stalled with %0d of %0d slots used",
                                           grp_addr_cnt, QUEUE_DEPTH));
                end
            end
            if (in_addr_valid && in_addr_ready) begin
                if (sb_addr_seen[in_addr_tag]) begin
                    note_failure($sformatf("address tag %0h sent twice while in flight",
                                           in_addr_tag));
                end
                sb_addr_seen[in_addr_tag] = 1'b1;
                sb_addr_edge[in_addr_tag] = edge_idx;
                sb_data[in_addr_tag]      = ref_mem[in_addr];
                grp_addr_cnt++;
            end
            if (in_ctrl_valid && in_ctrl_ready) begin
                sb_ctrl_seen[in_ctrl_tag] = 1'b1;
                sb_ctrl_edge[in_ctrl_tag] = edge_idx;
                grp_ctrl_cnt++;
            end
            // A stalled response must hold its payload
            if (prev_stall) begin
                check_bit("out_valid", 1'b1, out_valid);
                check_tag("out_tag", prev_tag, out_tag);
                check_elem("out_data", prev_data, out_data);
            end else if (out_valid) begin
                if (!sb_addr_seen[out_tag] || !sb_ctrl_seen[out_tag]) begin
                    note_failure($sformatf("response with tag %0h while that tag is not in flight",
                                           out_tag));
                end else begin
                    later = (sb_addr_edge[out_tag] > sb_ctrl_edge[out_tag]) ?
                            sb_addr_edge[out_tag] : sb_ctrl_edge[out_tag];
                    if (edge_idx < later + 2) begin
                        note_failure($sformatf("response for tag %0h came before its pair matched",
                                               out_tag));
                    end else if (exact_timing && edge_idx > later + 2) begin
                        note_failure($sformatf("response for tag %0h came %0d cycles late",
                                               out_tag, edge_idx - later - 2));
                    end
                    check_elem("out_data", sb_data[out_tag], out_data);
                end
            end
            if (out_valid && out_ready && sb_addr_seen[out_tag] && sb_ctrl_seen[out_tag]) begin
                sb_addr_seen[out_tag] = 1'b0;
                sb_ctrl_seen[out_tag] = 1'b0;
                rsp_count++;
            end
            prev_stall = out_valid && !out_ready;
            prev_tag   = out_tag;
            prev_data  = out_data;
        end
    end

    // ----------------------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------------------

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        errors++;
        $display("Timeout: run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Responses checked %0d, errors %0d", rsp_count, errors);
        $display("Simulation FAILED");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        int first;
        seed          = 32'h27db_438b;
        in_addr_valid = 1'b0;
        in_addr_tag   = '0;
        in_addr       = '0;
        in_ctrl_valid = 1'b0;
        in_ctrl_tag   = '0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;

        // Single load, then a rewrite of the same word and a second load
        add_row(1, 8'h12, 4'h1, 0, 1, 4'h1, 0, 0, 8'hFF, 0, 1);
        add_row(1, 8'h12, 4'h2, 0, 1, 4'h2, 0, 1, 8'hFF, 0, 1);
        // Control token first, then an address far ahead of its control token
        add_row(1, 8'h40, 4'h3, 6, 1, 4'h3, 0, 0, 8'hFF, 0, 1);
        add_row(1, 8'h41, 4'h4, 0, 1, 4'h4, 10, 0, 8'hFF, 0, 1);
        // Addresses A then B, control for B then for A
        add_row(1, 8'h50, 4'h5, 0, 1, 4'h6, 3, 0, 8'hFF, 0, 0);
        add_row(1, 8'h51, 4'h6, 0, 1, 4'h5, 4, 0, 8'hFF, 0, 1);
        // Five addresses into a four-slot queue with the control tokens much later
        for (int k = 0; k < 5; k++) begin
            add_row(1, addr_t'(8'h60 + k), tag_t'(7 + k), 0, 0, '0, 0, 0, 8'hFF, k == 0, 0);
        end
        for (int k = 0; k < 5; k++) begin
            add_row(0, '0, '0, 0, 1, tag_t'(7 + k), (k == 0) ? 12 : 1, 0, 8'hFF, 0, k == 4);
        end
        build_random_rows();

        wait (rst_n === 1'b1);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("in_addr_ready", 1'b1, in_addr_ready);
        check_bit("in_ctrl_ready", 1'b1, in_ctrl_ready);

        for (int a = 0; a < MEM_WORDS; a++) begin
            write_word(addr_t'(a), elem_t'($random(seed)));
        end

        first = 0;
        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].last) begin
                run_group(first, i);
                first = i + 1;
            end
        end

        idle_cycles(4);
        check_bit("out_valid", 1'b0, out_valid);
        $display("Responses checked %0d of %0d, errors %0d", rsp_count, exp_total, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released 1 ns after the last reset edge, in step with the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== load_top.sv ====
`timescale 1ns/1ps

module load_top #(
    parameter int ADDR_WIDTH  = load_pkg::ADDR_WIDTH,
    parameter int ELEM_WIDTH  = load_pkg::ELEM_WIDTH,
    parameter int TAG_WIDTH   = load_pkg::TAG_WIDTH,
    parameter int QUEUE_DEPTH = load_pkg::QUEUE_DEPTH
) (
    input  logic            clk,
    input  logic            rst_n,

    // Address stream
    input  logic            in_addr_valid,
    output logic            in_addr_ready,
    input  load_pkg::tag_t  in_addr_tag,
    input  load_pkg::addr_t in_addr,

    // Control token stream
    input  logic            in_ctrl_valid,
    output logic            in_ctrl_ready,
    input  load_pkg::tag_t  in_ctrl_tag,

    // Response stream
    output logic            out_valid,
    input  logic            out_ready,
    output load_pkg::tag_t  out_tag,
    output load_pkg::elem_t out_data,

    // Memory write port
    input  logic            wr_en,
    input  load_pkg::addr_t wr_addr,
    input  load_pkg::elem_t wr_data
);

    // --------------------------------------------------------------------
    // Streams between the processing element and the memory
    // --------------------------------------------------------------------

    tag_stream_if #(.DATA_WIDTH(ADDR_WIDTH)) req_if ();
    tag_stream_if #(.DATA_WIDTH(ELEM_WIDTH)) rsp_if ();

    // --------------------------------------------------------------------
    // Load processing element
    // --------------------------------------------------------------------

    load_pe #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .TAG_WIDTH   (TAG_WIDTH),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) pe_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_addr_valid (in_addr_valid),
        .in_addr_ready (in_addr_ready),
        .in_addr_tag   (in_addr_tag),
        .in_addr       (in_addr),
        .in_ctrl_valid (in_ctrl_valid),
        .in_ctrl_ready (in_ctrl_ready),
        .in_ctrl_tag   (in_ctrl_tag),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_tag       (out_tag),
        .out_data      (out_data),
        .req_if        (req_if.source),
        .rsp_if        (rsp_if.sink)
    );

    // --------------------------------------------------------------------
    // Local memory
    // --------------------------------------------------------------------

    load_mem #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .ELEM_WIDTH (ELEM_WIDTH)
    ) mem_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .req_if  (req_if.sink),
        .rsp_if  (rsp_if.source)
    );

endmodule

// ==== load_mem.sv ====
`timescale 1ns/1ps

module load_mem #(
    parameter int ADDR_WIDTH = load_pkg::ADDR_WIDTH,
    parameter int ELEM_WIDTH = load_pkg::ELEM_WIDTH
) (
    input  logic            clk,
    input  logic            rst_n,

    // Write port for loading the memory contents
    input  logic            wr_en,
    input  load_pkg::addr_t wr_addr,
    input  load_pkg::elem_t wr_data,

    tag_stream_if.sink      req_if,
    tag_stream_if.source    rsp_if
);
    import load_pkg::*;

    localparam int MEM_WORDS = 2 ** ADDR_WIDTH;

    logic [ELEM_WIDTH-1:0] mem [MEM_WORDS];

    // One-entry response register
    logic                  rsp_valid;
    tag_t                  rsp_tag;
    logic [ELEM_WIDTH-1:0] rsp_data;

    addr_t                 rd_addr;
    logic                  req_fire;

    // --------------------------------------------------------------------
    // Request side
    // --------------------------------------------------------------------

    // Accept when the register is empty or drains in this very cycle
    assign req_if.ready = !rsp_valid || rsp_if.ready;
    assign req_fire     = req_if.valid && req_if.ready;
    assign rd_addr      = req_if.data;

    // --------------------------------------------------------------------
    // Storage
    // --------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // --------------------------------------------------------------------
    // Response register
    // --------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_if.ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // A same-cycle write to rd_addr is not seen here, the old word is returned
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_tag  <= req_if.tag;
            rsp_data <= mem[rd_addr];
        end
    end

    assign rsp_if.valid = rsp_valid;
    assign rsp_if.tag   = rsp_tag;
    assign rsp_if.data  = rsp_data;

endmodule

// ==== load_pe.sv ====
`timescale 1ns/1ps

module load_pe #(
    parameter int ADDR_WIDTH  = load_pkg::ADDR_WIDTH,
    parameter int TAG_WIDTH   = load_pkg::TAG_WIDTH,
    parameter int QUEUE_DEPTH = load_pkg::QUEUE_DEPTH
) (
    input  logic            clk,
    input  logic            rst_n,

    // Address stream from the compute side
    input  logic            in_addr_valid,
    output logic            in_addr_ready,
    input  load_pkg::tag_t  in_addr_tag,
    input  load_pkg::addr_t in_addr,

    // Control token stream from the compute side
    input  logic            in_ctrl_valid,
    output logic            in_ctrl_ready,
    input  load_pkg::tag_t  in_ctrl_tag,

    // Loaded elements back to the compute side
    output logic            out_valid,
    input  logic            out_ready,
    output load_pkg::tag_t  out_tag,
    output load_pkg::elem_t out_data,

    tag_stream_if.source    req_if,
    tag_stream_if.sink      rsp_if
);
    import load_pkg::*;

    localparam int IDX_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    // Address queue slots
    logic [QUEUE_DEPTH-1:0] addr_slot_valid;
    logic [TAG_WIDTH-1:0]   addr_slot_tag  [QUEUE_DEPTH];
    logic [ADDR_WIDTH-1:0]  addr_slot_addr [QUEUE_DEPTH];

    // Control queue slots carry only a tag
    logic [QUEUE_DEPTH-1:0] ctrl_slot_valid;
    logic [TAG_WIDTH-1:0]   ctrl_slot_tag  [QUEUE_DEPTH];

    logic             addr_free_found;
    logic [IDX_W-1:0] addr_free_idx;
    logic             ctrl_free_found;
    logic [IDX_W-1:0] ctrl_free_idx;

    logic             match_found;
    logic [IDX_W-1:0] match_addr_idx;
    logic [IDX_W-1:0] match_ctrl_idx;
    tag_t             match_tag;
    addr_t            match_addr;
    logic             match_fire;

    logic             addr_push;
    logic             ctrl_push;
    logic [IDX_W-1:0] addr_push_idx;
    logic [IDX_W-1:0] ctrl_push_idx;

    // Lowest-numbered empty slot, returned as {found, index}
    function automatic logic [IDX_W:0] first_free(input logic [QUEUE_DEPTH-1:0] used);
        logic [IDX_W:0] result;
        result = '0;
        for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
            if (!used[i]) begin
                result = {1'b1, IDX_W'(i)};
            end
        end
        return result;
    endfunction

    // --------------------------------------------------------------------
    // Slot allocation
    // --------------------------------------------------------------------

    assign {addr_free_found, addr_free_idx} = first_free(addr_slot_valid);
    assign {ctrl_free_found, ctrl_free_idx} = first_free(ctrl_slot_valid);

    // A slot emptied by the outgoing request may take a new token at the same edge
    assign in_addr_ready = addr_free_found || match_fire;
    assign in_ctrl_ready = ctrl_free_found || match_fire;

    assign addr_push_idx = addr_free_found ? addr_free_idx : match_addr_idx;
    assign ctrl_push_idx = ctrl_free_found ? ctrl_free_idx : match_ctrl_idx;

    assign addr_push = in_addr_valid && in_addr_ready;
    assign ctrl_push = in_ctrl_valid && in_ctrl_ready;

    // --------------------------------------------------------------------
    // Tag matching
    // --------------------------------------------------------------------

    // Oldest position wins: lowest address slot first, then lowest control slot
    always_comb begin
        match_found    = 1'b0;
        match_addr_idx = '0;
        match_ctrl_idx = '0;
        for (int a = 0; a < QUEUE_DEPTH; a++) begin
            for (int c = 0; c < QUEUE_DEPTH; c++) begin
                if (!match_found && addr_slot_valid[a] && ctrl_slot_valid[c] &&
                    addr_slot_tag[a] == ctrl_slot_tag[c]) begin
                    match_found    = 1'b1;
                    match_addr_idx = IDX_W'(a);
                    match_ctrl_idx = IDX_W'(c);
                end
            end
        end
    end

    assign match_tag  = addr_slot_tag[match_addr_idx];
    assign match_addr = addr_slot_addr[match_addr_idx];
    assign match_fire = match_found && req_if.ready;

    assign req_if.valid = match_found;
    assign req_if.tag   = match_tag;
    assign req_if.data  = match_addr;

    // --------------------------------------------------------------------
    // Queue state
    // --------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_slot_valid <= '0;
            ctrl_slot_valid <= '0;
        end else begin
            if (match_fire) begin
                addr_slot_valid[match_addr_idx] <= 1'b0;
                ctrl_slot_valid[match_ctrl_idx] <= 1'b0;
            end
            // A push into a slot that is also being popped must win
            if (addr_push) begin
                addr_slot_valid[addr_push_idx] <= 1'b1;
            end
            if (ctrl_push) begin
                ctrl_slot_valid[ctrl_push_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_push) begin
            addr_slot_tag[addr_push_idx]  <= in_addr_tag;
            addr_slot_addr[addr_push_idx] <= in_addr;
        end
        if (ctrl_push) begin
            ctrl_slot_tag[ctrl_push_idx] <= in_ctrl_tag;
        end
    end

    // --------------------------------------------------------------------
    // Response path
    // --------------------------------------------------------------------

    // Memory responses already carry the address tag, so they go out as they are
    assign out_valid    = rsp_if.valid;
    assign out_tag      = rsp_if.tag;
    assign out_data     = rsp_if.data;
    assign rsp_if.ready = out_ready;

endmodule

// ==== tag_stream_if.sv ====
`timescale 1ns/1ps

interface tag_stream_if #(
    parameter int DATA_WIDTH = load_pkg::ADDR_WIDTH
);
    import load_pkg::*;

    logic                  valid;
    logic                  ready;
    tag_t                  tag;
    logic [DATA_WIDTH-1:0] data;

    // The source drives the token, the sink answers with ready
    modport source (
        output valid,
        input  ready,
        output tag,
        output data
    );

    modport sink (
        input  valid,
        output ready,
        input  tag,
        input  data
    );

endinterface

// ==== load_pkg.sv ====
package load_pkg;

    // ----------------------------------------------------------------------
    // Default widths of the load path
    // ----------------------------------------------------------------------

    // Address width, 8 bits gives a 256-word local memory
    parameter int ADDR_WIDTH = 8;

    // Width of one loaded data element
    parameter int ELEM_WIDTH = 32;

    // Width of the token tag used for matching
    parameter int TAG_WIDTH = 4;

    // Number of slots in each of the address and control queues
    parameter int QUEUE_DEPTH = 4;

    // ----------------------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------------------

    // Word address into the local memory
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Element returned by a load
    typedef logic [ELEM_WIDTH-1:0] elem_t;

    // Tag that travels with every token in the fabric
    typedef logic [TAG_WIDTH-1:0] tag_t;

endpackage
